// File: fedp_consts.svh
`ifndef FEDP_CONSTS_SVH
`define FEDP_CONSTS_SVH

// Accumulator width
// 1 sign bit, 2 headroom bits, 27 bits from the aligned top of the largest term down
`define FEDP_WA 30

// Signed exponent width inside the datapath
// Holds bf16 product exponents (ea + eb - 127) without wrapping
`define FEDP_EXP_W 10

// Integer mode, addend bits 31..25 bypass the accumulator
`define FEDP_C_HI_W 7

// Operand pairs per dot product
`define FEDP_TERMS 2

`endif

// File: fedp_pkg.sv
`include "fedp_consts.svh"

package fedp_pkg;

    // Special-value summary, settled in the multiply stage
    typedef struct packed {
        logic is_nan;
        logic is_inf;
        logic sign;
    } fedp_excep_t;

    // Incoming request, bf16/int8 pairs plus fp32/int32 addend
    typedef struct packed {
        logic [31:0]                  req_id;
        logic                         is_int;
        logic [`FEDP_TERMS-1:0][15:0] a;
        logic [`FEDP_TERMS-1:0][15:0] b;
        logic [31:0]                  c;
    } fedp_req_t;

    // One product term
    // mant is the 8x8 mantissa product, or the signed int8 product in integer mode
    typedef struct packed {
        logic                   sign;
        logic [`FEDP_EXP_W-1:0] exp;
        logic [15:0]            mant;
        logic                   zero;
    } fedp_prod_t;

    // Multiply stage output register
    typedef struct packed {
        logic [31:0]                   req_id;
        logic                          is_int;
        fedp_prod_t [`FEDP_TERMS-1:0]  prod;
        logic                          c_sign;
        logic [`FEDP_EXP_W-1:0]        c_exp;
        logic [23:0]                   c_man;
        logic                          c_zero;
        logic [31:0]                   c_raw;
        fedp_excep_t                   excep;
    } fedp_mul_t;

    // Align/accumulate stage output register
    typedef struct packed {
        logic [31:0]             req_id;
        logic                    is_int;
        logic [`FEDP_EXP_W-1:0]  max_exp;
        logic [`FEDP_WA-1:0]     acc_sig;
        logic [`FEDP_C_HI_W-1:0] cval_hi;
        logic                    sticky;
        fedp_excep_t             excep;
    } fedp_acc_t;

    // Response back to the tensor core
    typedef struct packed {
        logic [31:0] req_id;
        logic [31:0] result;
    } fedp_rsp_t;

endpackage

// File: fedp_lzc.sv
module fedp_lzc #(
    parameter int N = 30
) (
    input  logic [N-1:0]         data_in,
    output logic [$clog2(N)-1:0] data_out,
    output logic                 valid_out
);

    localparam int CW = $clog2(N);

    // Set once the first one has been seen from the top
    logic found;

    // Priority search, MSB first
    // An all-zero input reports N-1, the shift that still lands bit 0 on top
    always_comb begin
        found    = 1'b0;
        data_out = CW'(N - 1);
        for (int i = N - 1; i >= 0; i--) begin
            if (!found && data_in[i]) begin
                data_out = CW'(N - 1 - i);
                found    = 1'b1;
            end
        end
    end

    // Any bit set
    assign valid_out = |data_in;

endmodule

// File: fedp_mul_stage.sv
`include "fedp_consts.svh"

module fedp_mul_stage import fedp_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      valid_in,
    input  fedp_req_t req,
    output logic      mul_valid,
    output fedp_mul_t mul
);

    localparam int EXP_W = `FEDP_EXP_W;
    localparam int TERMS = `FEDP_TERMS;
    localparam int BIAS  = 127;

    // Per-operand classification
    logic [TERMS-1:0] a_zero, a_inf, a_nan;
    logic [TERMS-1:0] b_zero, b_inf, b_nan;

    // Per-product classification
    logic [TERMS-1:0] p_sign, p_inf, p_nan;

    // Addend classification
    logic c_zero, c_inf, c_nan;

    // Infinity bookkeeping across all terms
    logic pos_inf, neg_inf, any_nan;

    fedp_mul_t mul_d;

    // ==============================
    // Operand decode and products
    // ==============================

    always_comb begin
        mul_d        = '0;
        mul_d.req_id = req.req_id;
        mul_d.is_int = req.is_int;

        for (int t = 0; t < TERMS; t++) begin
            // bf16: sign[15], exp[14:7], man[6:0]
            a_zero[t] = (req.a[t][14:7] == 8'h00);
            a_inf[t]  = (req.a[t][14:7] == 8'hff) && (req.a[t][6:0] == 7'h00);
            a_nan[t]  = (req.a[t][14:7] == 8'hff) && (req.a[t][6:0] != 7'h00);
            b_zero[t] = (req.b[t][14:7] == 8'h00);
            b_inf[t]  = (req.b[t][14:7] == 8'hff) && (req.b[t][6:0] == 7'h00);
            b_nan[t]  = (req.b[t][14:7] == 8'hff) && (req.b[t][6:0] != 7'h00);

            p_sign[t] = req.a[t][15] ^ req.b[t][15];
            // inf * 0 is invalid
            p_nan[t]  = a_nan[t] | b_nan[t] | (a_inf[t] & b_zero[t]) | (b_inf[t] & a_zero[t]);
            p_inf[t]  = (a_inf[t] | b_inf[t]) & ~p_nan[t];

            if (req.is_int) begin
                // Signed int8 x int8, sign-extended to 16 bits first
                mul_d.prod[t].mant = {{8{req.a[t][7]}}, req.a[t][7:0]}
                                   * {{8{req.b[t][7]}}, req.b[t][7:0]};
            end else begin
                mul_d.prod[t].sign = p_sign[t];
                // Bias removed once, result is the biased exponent of the product
                mul_d.prod[t].exp  = EXP_W'(req.a[t][14:7]) + EXP_W'(req.b[t][14:7])
                                   - EXP_W'(BIAS);
                // 1.7 x 1.7 gives 2.14 format
                mul_d.prod[t].mant = {1'b1, req.a[t][6:0]} * {1'b1, req.b[t][6:0]};
                // Denormals flush to zero
                mul_d.prod[t].zero = a_zero[t] | b_zero[t];
            end
        end

        // fp32 addend decode
        c_zero = (req.c[30:23] == 8'h00);
        c_inf  = (req.c[30:23] == 8'hff) && (req.c[22:0] == 23'd0);
        c_nan  = (req.c[30:23] == 8'hff) && (req.c[22:0] != 23'd0);

        mul_d.c_sign = req.c[31];
        mul_d.c_exp  = EXP_W'(req.c[30:23]);
        mul_d.c_man  = {1'b1, req.c[22:0]};
        mul_d.c_zero = c_zero;
        // Integer mode uses the raw word downstream
        mul_d.c_raw  = req.c;

        // Opposite infinities anywhere in the sum are invalid
        pos_inf = (|(p_inf & ~p_sign)) | (c_inf & ~req.c[31]);
        neg_inf = (|(p_inf & p_sign)) | (c_inf & req.c[31]);
        any_nan = (|p_nan) | c_nan | (pos_inf & neg_inf);

        mul_d.excep.is_nan = ~req.is_int & any_nan;
        mul_d.excep.is_inf = ~req.is_int & ~any_nan & (pos_inf | neg_inf);
        mul_d.excep.sign   = neg_inf;
    end

    // ==============================
    // Stage register
    // ==============================

    always_ff @(posedge clk) begin
        if (rst) begin
            mul_valid <= 1'b0;
        end else begin
            mul_valid <= valid_in;
        end
    end

    // Payload only loads on a valid request
    always_ff @(posedge clk) begin
        if (valid_in) begin
            mul <= mul_d;
        end
    end

endmodule

// File: fedp_align_acc.sv
`include "fedp_consts.svh"

module fedp_align_acc import fedp_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      mul_valid,
    input  fedp_mul_t mul,
    output logic      acc_valid,
    output fedp_acc_t acc
);

    localparam int WA     = `FEDP_WA;
    localparam int EXP_W  = `FEDP_EXP_W;
    localparam int TERMS  = `FEDP_TERMS;
    localparam int C_HI_W = `FEDP_C_HI_W;
    localparam int LO_W   = 32 - C_HI_W;

    // Aligned field, bits 26:0, the largest term's 2^0 sits at bit FW-2
    localparam int FW = 27;

    // Leading one at bit WA-1 maps to max_exp, so offset from the 2^0 position
    localparam int EXP_OFS = (WA - 1) - (FW - 2);

    // Right-shift a magnitude into the aligned field
    // Returns {aligned, sticky}, sticky is the OR of every bit shifted out
    function automatic logic [FW:0] align_term(input logic [FW-1:0]    mag,
                                               input logic [EXP_W-1:0] shift);
        logic [2*FW-1:0] ext;
        logic [FW:0]     res;
        ext = {mag, {FW{1'b0}}} >> shift;
        if (shift >= EXP_W'(FW)) begin
            res = {{FW{1'b0}}, |mag};
        end else begin
            res = {ext[2*FW-1:FW], |ext[FW-1:0]};
        end
        return res;
    endfunction

    logic signed [EXP_W-1:0] e_max;
    logic [FW-1:0]           mag;
    logic [FW:0]             al_res;
    logic [WA-1:0]           term;
    logic [WA-1:0]           sum_fp;
    logic [WA-1:0]           sum_int;
    logic                    sticky_fp;
    fedp_acc_t               acc_d;

    // ==============================
    // Max exponent search
    // ==============================

    // Zero terms do not take part, start from the most negative exponent
    always_comb begin
        e_max = {1'b1, {(EXP_W-1){1'b0}}};
        for (int t = 0; t < TERMS; t++) begin
            if (!mul.prod[t].zero && ($signed(mul.prod[t].exp) > e_max)) begin
                e_max = mul.prod[t].exp;
            end
        end
        if (!mul.c_zero && ($signed(mul.c_exp) > e_max)) begin
            e_max = mul.c_exp;
        end
    end

    // ==============================
    // Alignment and accumulation
    // ==============================

    always_comb begin
        sum_fp    = '0;
        sticky_fp = 1'b0;

        // Products are 2.14, bit 14 lands on FW-2
        for (int t = 0; t < TERMS; t++) begin
            mag       = mul.prod[t].zero ? '0 : {mul.prod[t].mant, {(FW-16){1'b0}}};
            al_res    = align_term(mag, EXP_W'(e_max - $signed(mul.prod[t].exp)));
            sticky_fp = sticky_fp | al_res[0];
            term      = WA'(al_res[FW:1]);
            sum_fp    = mul.prod[t].sign ? (sum_fp - term) : (sum_fp + term);
        end

        // Addend is 1.23, hidden bit also on FW-2
        mag       = mul.c_zero ? '0 : {1'b0, mul.c_man, 2'b00};
        al_res    = align_term(mag, EXP_W'(e_max - $signed(mul.c_exp)));
        sticky_fp = sticky_fp | al_res[0];
        term      = WA'(al_res[FW:1]);
        sum_fp    = mul.c_sign ? (sum_fp - term) : (sum_fp + term);
    end

    // Integer path, low addend bits are unsigned, the high part is merged at the end
    always_comb begin
        sum_int = WA'(mul.c_raw[LO_W-1:0]);
        for (int t = 0; t < TERMS; t++) begin
            sum_int = sum_int + WA'($signed(mul.prod[t].mant));
        end
    end

    always_comb begin
        acc_d.req_id  = mul.req_id;
        acc_d.is_int  = mul.is_int;
        acc_d.max_exp = mul.is_int ? '0 : EXP_W'(e_max + EXP_W'(EXP_OFS));
        acc_d.acc_sig = mul.is_int ? sum_int : sum_fp;
        acc_d.cval_hi = mul.c_raw[31 -: C_HI_W];
        acc_d.sticky  = mul.is_int ? 1'b0 : sticky_fp;
        acc_d.excep   = mul.excep;
    end

    // ==============================
    // Stage register
    // ==============================

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_valid <= 1'b0;
        end else begin
            acc_valid <= mul_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mul_valid) begin
            acc <= acc_d;
        end
    end

endmodule

// File: fedp_norm_round.sv
`include "fedp_consts.svh"

module fedp_norm_round import fedp_pkg::*; #(
    parameter int WA     = `FEDP_WA,
    parameter int EXP_W  = `FEDP_EXP_W,
    parameter int C_HI_W = `FEDP_C_HI_W
) (
    input  logic                    clk,
    input  logic                    valid_in,
    input  logic [31:0]             req_id,
    input  logic signed [EXP_W-1:0] max_exp,
    input  logic [WA-1:0]           acc_sig,
    input  logic [C_HI_W-1:0]       cval_hi,
    input  logic                    is_int,
    input  logic                    sticky_in,
    input  fedp_excep_t             exceptions,
    output logic [31:0]             result
);

    localparam int LZ_W  = $clog2(WA);
    localparam int LO_W  = 32 - C_HI_W;
    // 24-bit mantissa plus guard, round, sticky
    localparam int WIN_W = 27;

    // ==============================
    // Magnitude, LZC, exponent
    // ==============================

    logic                    sum_sign;
    logic [WA-1:0]           acc_inv;
    logic [WA-1:0]           abs_sum;
    logic                    zero_sum;
    logic [LZ_W-1:0]         lz_pred;
    logic signed [EXP_W-1:0] exp_base;
    logic signed [EXP_W-1:0] exp_plus1;
    logic signed [EXP_W-1:0] exp_plus2;

    assign sum_sign = acc_sig[WA-1];

    // Ones' complement feeds the LZC so it runs beside the increment
    assign acc_inv  = acc_sig ^ {WA{sum_sign}};
    assign abs_sum  = acc_inv + WA'(sum_sign);
    assign zero_sum = (abs_sum == '0);

    // Count may be one too high for negative sums, fixed after the shift
    fedp_lzc #(
        .N (WA)
    ) u_lzc (
        .data_in   (acc_inv),
        .data_out  (lz_pred),
        .valid_out ()
    );

    assign exp_base  = max_exp - EXP_W'(lz_pred);
    assign exp_plus1 = exp_base + EXP_W'(1);
    assign exp_plus2 = exp_base + EXP_W'(2);

    // ==============================
    // Shift and overshift fix
    // ==============================

    logic [WA:0]      shifted;
    logic             overshift;
    logic [WIN_W-1:0] win;

    // One spare bit on top catches the overshift
    assign shifted   = {1'b0, abs_sum} << lz_pred;
    assign overshift = shifted[WA];
    assign win       = overshift ? shifted[WA -: WIN_W] : shifted[WA-1 -: WIN_W];

    // ==============================
    // Round to nearest even
    // ==============================

    logic [23:0] norm_man;
    logic        guard_bit;
    logic        round_bit;
    logic        sticky_bit;
    logic        round_up;
    logic [24:0] man_rnd;
    logic        carry_out;
    logic [22:0] final_man;

    assign norm_man   = win[WIN_W-1:3];
    assign guard_bit  = win[2];
    assign round_bit  = win[1];
    // Bits below the window plus everything lost during alignment
    assign sticky_bit = win[0] | (|shifted[WA-WIN_W:0]) | sticky_in;

    // Above half, or exactly half with an odd LSB
    assign round_up  = guard_bit & (round_bit | sticky_bit | norm_man[0]);
    assign man_rnd   = {1'b0, norm_man} + 25'(round_up);
    assign carry_out = man_rnd[24];
    // Carry leaves 1.000..0, drop one position
    assign final_man = carry_out ? man_rnd[23:1] : man_rnd[22:0];

    // ==============================
    // Exponent limits and packing
    // ==============================

    logic signed [EXP_W-1:0] final_exp;
    logic                    exp_ovf;
    logic                    exp_unf;
    logic [31:0]             fp_result;

    always_comb begin
        case ({overshift, carry_out})
            2'b00:   final_exp = exp_base;
            2'b11:   final_exp = exp_plus2;
            // Either correction alone
            default: final_exp = exp_plus1;
        endcase
    end

    assign exp_ovf = (final_exp >= 255);
    assign exp_unf = (final_exp <= 0);

    // Exceptions first, then zero, then range limits
    always_comb begin
        if (exceptions.is_nan) begin
            fp_result = 32'h7fc0_0000;
        end else if (exceptions.is_inf) begin
            fp_result = {exceptions.sign, 8'hff, 23'd0};
        end else if (zero_sum) begin
            fp_result = 32'h0000_0000;
        end else if (exp_ovf) begin
            fp_result = {sum_sign, 8'hff, 23'd0};
        end else if (exp_unf) begin
            // No denormal output, flush
            fp_result = {sum_sign, 31'd0};
        end else begin
            fp_result = {sum_sign, final_exp[7:0], final_man};
        end
    end

    // ==============================
    // Integer merge
    // ==============================

    logic [C_HI_W-1:0] acc_hi;
    logic [C_HI_W-1:0] int_hi;
    logic [31:0]       int_result;

    // Carries out of the low field, sign-extended
    assign acc_hi     = C_HI_W'($signed(acc_sig[WA-1:LO_W]));
    assign int_hi     = cval_hi + acc_hi;
    assign int_result = {int_hi, acc_sig[LO_W-1:0]};

    assign result = is_int ? int_result : fp_result;

endmodule

// File: fedp_unit.sv
module fedp_unit import fedp_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      valid_in,
    input  fedp_req_t req,
    output logic      valid_out,
    output fedp_rsp_t rsp
);

    // Stage 1 to stage 2
    logic      mul_valid;
    fedp_mul_t mul;

    // Stage 2 to stage 3
    logic      acc_valid;
    fedp_acc_t acc;

    // Combinational result of the last stage
    logic [31:0] result;

    // ==============================
    // Pipeline
    // ==============================

    // Decode, products, special values
    fedp_mul_stage u_mul_stage (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (valid_in),
        .req       (req),
        .mul_valid (mul_valid),
        .mul       (mul)
    );

    // Align to the largest exponent and sum
    fedp_align_acc u_align_acc (
        .clk       (clk),
        .rst       (rst),
        .mul_valid (mul_valid),
        .mul       (mul),
        .acc_valid (acc_valid),
        .acc       (acc)
    );

    // Normalize, round and merge the integer result
    fedp_norm_round u_norm_round (
        .clk        (clk),
        .valid_in   (acc_valid),
        .req_id     (acc.req_id),
        .max_exp    (acc.max_exp),
        .acc_sig    (acc.acc_sig),
        .cval_hi    (acc.cval_hi),
        .is_int     (acc.is_int),
        .sticky_in  (acc.sticky),
        .exceptions (acc.excep),
        .result     (result)
    );

    // Third cycle, response register
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= acc_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (acc_valid) begin
            rsp.req_id <= acc.req_id;
            rsp.result <= result;
        end
    end

endmodule

// File: tb_fedp_unit.sv
`include "fedp_consts.svh"

module tb_fedp_unit import fedp_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // About 270 requests plus drains and reset come to roughly 320 cycles
    localparam int MAX_CYCLES = 2000;

    logic      clk;
    logic      rst;
    logic      valid_in;
    fedp_req_t req;
    logic      valid_out;
    fedp_rsp_t rsp;

    // Expected responses, oldest first
    logic [31:0] tag_q[$];
    logic [31:0] res_q[$];

    int          seed = 32'h92eb;
    logic [31:0] next_tag;
    int          cycle_count;
    string       test_name;
    int          mon_errs;
    int          sva_errs;
    int          rst_errs;
    int          checks;
    int          errs_start;
    int          checks_start;
    int          tests_run;
    int          tests_bad;

    fedp_unit u_fedp_unit (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (valid_in),
        .req       (req),
        .valid_out (valid_out),
        .rsp       (rsp)
    );

    always #10 clk = ~clk;

    // ==============================
    // Reference model
    // ==============================

    function automatic real pow2(input int e);
        real r;
        r = 1.0;
        for (int i = 0; i < e; i++) begin
            r = r * 2.0;
        end
        for (int i = 0; i < -e; i++) begin
            r = r / 2.0;
        end
        return r;
    endfunction

    // Exponent zero reads as zero, no denormals
    function automatic real bf16_val(input logic [15:0] x);
        real r;
        r = (x[14:7] == 8'h00) ? 0.0 : (1.0 + real'(x[6:0]) / 128.0) * pow2(int'(x[14:7]) - 127);
        return x[15] ? -r : r;
    endfunction

    function automatic real fp32_val(input logic [31:0] x);
        real r;
        r = (x[30:23] == 8'h00) ? 0.0
          : (1.0 + real'(x[22:0]) / 8388608.0) * pow2(int'(x[30:23]) - 127);
        return x[31] ? -r : r;
    endfunction

    // Real to fp32, nearest even, flush below the normal range
    function automatic logic [31:0] fp32_bits(input real x);
        logic sign;
        real  mag;
        real  scaled;
        real  rem;
        int   e;
        int   m;
        if (x == 0.0) begin
            return 32'h0000_0000;
        end
        sign = (x < 0.0);
        mag  = sign ? -x : x;
        e    = 0;
        while (mag >= 2.0) begin
            mag = mag / 2.0;
            e++;
        end
        while (mag < 1.0) begin
            mag = mag * 2.0;
            e--;
        end
        scaled = mag * 8388608.0;
        m      = $rtoi(scaled);
        rem    = scaled - real'(m);
        if (rem > 0.5 || (rem == 0.5 && m[0])) begin
            m++;
        end
        // Mantissa overflow bumps the exponent
        if (m == 16777216) begin
            m = 8388608;
            e++;
        end
        if (e + 127 >= 255) begin
            return {sign, 8'hff, 23'd0};
        end
        if (e + 127 <= 0) begin
            return {sign, 31'd0};
        end
        return {sign, 8'(e + 127), m[22:0]};
    endfunction

    function automatic logic [31:0] fp_model(input logic [`FEDP_TERMS-1:0][15:0] a,
                                             input logic [`FEDP_TERMS-1:0][15:0] b,
                                             input logic [31:0]                  c);
        logic any_nan;
        logic pos_inf;
        logic neg_inf;
        logic a_inf;
        logic b_inf;
        logic p_nan;
        real  sum;
        any_nan = (c[30:23] == 8'hff) && (c[22:0] != 23'd0);
        pos_inf = (c[30:23] == 8'hff) && (c[22:0] == 23'd0) && !c[31];
        neg_inf = (c[30:23] == 8'hff) && (c[22:0] == 23'd0) && c[31];
        sum     = fp32_val(c);
        for (int t = 0; t < `FEDP_TERMS; t++) begin
            a_inf = (a[t][14:7] == 8'hff) && (a[t][6:0] == 7'd0);
            b_inf = (b[t][14:7] == 8'hff) && (b[t][6:0] == 7'd0);
            // NaN operand, or infinity times zero
            p_nan = ((a[t][14:7] == 8'hff) && (a[t][6:0] != 7'd0))
                 || ((b[t][14:7] == 8'hff) && (b[t][6:0] != 7'd0))
                 || (a_inf && b[t][14:7] == 8'h00) || (b_inf && a[t][14:7] == 8'h00);
            any_nan = any_nan | p_nan;
            if (!p_nan && (a_inf || b_inf)) begin
                if (a[t][15] ^ b[t][15]) begin
                    neg_inf = 1'b1;
                end else begin
                    pos_inf = 1'b1;
                end
            end
            sum = sum + bf16_val(a[t]) * bf16_val(b[t]);
        end
        if (any_nan || (pos_inf && neg_inf)) begin
            return 32'h7fc0_0000;
        end
        if (pos_inf || neg_inf) begin
            return {neg_inf, 8'hff, 23'd0};
        end
        return fp32_bits(sum);
    endfunction

    // Exact sum, wraps modulo 2^32
    function automatic logic [31:0] int_model(input logic [`FEDP_TERMS-1:0][15:0] a,
                                              input logic [`FEDP_TERMS-1:0][15:0] b,
                                              input logic [31:0]                  c);
        int acc;
        acc = int'(c);
        for (int t = 0; t < `FEDP_TERMS; t++) begin
            acc = acc + int'($signed(a[t][7:0])) * int'($signed(b[t][7:0]));
        end
        return acc;
    endfunction

    function automatic int total_errors();
        return mon_errs + sva_errs + rst_errs;
    endfunction

    // ==============================
    // Stimulus helpers
    // ==============================

    // Called 2 ns after a rising edge, returns 2 ns after the next one
    task automatic send_req(input logic is_int, input logic [15:0] a0, input logic [15:0] b0,
                            input logic [15:0] a1, input logic [15:0] b1,
                            input logic [31:0] c);
        logic [`FEDP_TERMS-1:0][15:0] av;
        logic [`FEDP_TERMS-1:0][15:0] bv;
        av         = {a1, a0};
        bv         = {b1, b0};
        req.req_id = next_tag;
        req.is_int = is_int;
        req.a      = av;
        req.b      = bv;
        req.c      = c;
        valid_in   = 1'b1;
        tag_q.push_back(next_tag);
        res_q.push_back(is_int ? int_model(av, bv, c) : fp_model(av, bv, c));
        next_tag++;
        @(posedge clk);
        #2;
    endtask

    task automatic send_fp(input logic [15:0] a0, input logic [15:0] b0,
                           input logic [15:0] a1, input logic [15:0] b1,
                           input logic [31:0] c);
        send_req(1'b0, a0, b0, a1, b1, c);
    endtask

    // Exponents 126..129 keep the sum within 24 significant bits
    function automatic logic [15:0] rand_bf16();
        logic [31:0] r;
        r = $random(seed);
        return {r[0], 8'(126 + r[2:1]), r[9:3]};
    endfunction

    task automatic send_rand_fp();
        logic [31:0] r;
        logic [31:0] c;
        r = $random(seed);
        case (r[1:0])
            2'd0:    c = 32'h0000_0000;
            2'd1:    c = 32'h3f80_0000;
            2'd2:    c = 32'hbf80_0000;
            default: c = 32'h4000_0000;
        endcase
        send_fp(rand_bf16(), rand_bf16(), rand_bf16(), rand_bf16(), c);
    endtask

    task automatic send_rand_int();
        logic [31:0] r;
        logic [31:0] c;
        r = $random(seed);
        c = $random(seed);
        send_req(1'b1, {{8{r[7]}}, r[7:0]}, {{8{r[15]}}, r[15:8]},
                 {{8{r[23]}}, r[23:16]}, {{8{r[31]}}, r[31:24]}, c);
    endtask

    task automatic idle(input int n);
        valid_in = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic begin_test(input string name);
        test_name    = name;
        errs_start   = total_errors();
        checks_start = checks;
    endtask

    // Drain the pipe, then report the test
    task automatic close_test();
        int errs;
        valid_in = 1'b0;
        while (tag_q.size() != 0) begin
            @(posedge clk);
            #2;
        end
        idle(2);
        errs = total_errors() - errs_start;
        tests_run++;
        if (errs != 0) begin
            tests_bad++;
        end
        $display("%-14s %4d responses checked, %0d errors", test_name,
                 checks - checks_start, errs);
    endtask

    // ==============================
    // Checking
    // ==============================

    // Fixed three-cycle latency, and no stray valid_out in idle gaps
    assert property (@(posedge clk) disable iff (rst) valid_out == $past(valid_in, 3))
        else begin
            sva_errs++;
            $display("valid_out does not match valid_in three cycles earlier (cycle %0d)",
                     cycle_count);
        end

    // Outputs sampled before the edge updates them
    always @(posedge clk) begin
        logic [31:0] exp_tag;
        logic [31:0] exp_res;
        if (!rst && valid_out) begin
            if (tag_q.size() == 0) begin
                mon_errs++;
                $display("Response with tag %h arrived with no request outstanding",
                         rsp.req_id);
            end else begin
                exp_tag = tag_q.pop_front();
                exp_res = res_q.pop_front();
                checks++;
                assert (rsp.req_id == exp_tag)
                    else begin
                        mon_errs++;
                        $display("FAILED %s tag: expected %h, actual %h", test_name,
                                 exp_tag, rsp.req_id);
                    end
                assert (rsp.result == exp_res)
                    else begin
                        mon_errs++;
                        $display("FAILED %s tag %h result: expected %h, actual %h",
                                 test_name, exp_tag, exp_res, rsp.result);
                    end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles in %s with %0d responses still missing",
                     cycle_count, test_name, tag_q.size());
            $display("Test failed");
            $finish;
        end
    end

    // ==============================
    // Test sequence
    // ==============================

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        valid_in  = 1'b0;
        req       = '0;
        next_tag  = 32'h0000_1000;
        test_name = "reset";

        repeat (8) begin
            @(posedge clk);
            #2;
            assert (valid_out === 1'b0)
                else begin
                    rst_errs++;
                    $display("valid_out is not low during reset");
                end
        end
        rst = 1'b0;
        idle(2);

        begin_test("exact_sums");
        // 6 - 6 + 1
        send_fp(16'h4000, 16'h4040, 16'hbfc0, 16'h4080, 32'h3f80_0000);
        // 6 - 8, negative power of two
        send_fp(16'h4000, 16'h4040, 16'h0000, 16'h0000, 32'hc100_0000);
        // 35 + 0.125 + 10
        send_fp(16'h40a0, 16'h40e0, 16'h3f00, 16'h3e80, 32'h4120_0000);
        send_fp(16'hc040, 16'h4040, 16'h4000, 16'h4000, 32'h3f40_0000);
        send_fp(16'h3f80, 16'h3f80, 16'h3f80, 16'h3f80, 32'h0000_0000);
        // Signed zero operands
        send_fp(16'h0000, 16'h4040, 16'h8000, 16'h3f80, 32'h3f00_0000);
        close_test();

        begin_test("rounding");
        // 1 + 2^-24, tie stays even
        send_fp(16'h3980, 16'h3980, 16'h0000, 16'h0000, 32'h3f80_0000);
        // Tie with odd LSB rounds up
        send_fp(16'h3980, 16'h3980, 16'h0000, 16'h0000, 32'h3f80_0001);
        send_fp(16'hb980, 16'h3980, 16'h0000, 16'h0000, 32'hbf80_0001);
        // Just above half an ulp, needs sticky
        send_fp(16'h3981, 16'h3980, 16'h0000, 16'h0000, 32'h3f80_0000);
        // Mantissa carry into the exponent
        send_fp(16'h3980, 16'h3980, 16'h0000, 16'h0000, 32'h3fff_ffff);
        close_test();

        begin_test("cancellation");
        send_fp(16'h4000, 16'h4040, 16'h0000, 16'h0000, 32'hc0c0_0000);
        send_fp(16'h3f81, 16'h3f81, 16'h0000, 16'h0000, 32'hbf80_0000);
        send_fp(16'hbf81, 16'h3f81, 16'h0000, 16'h0000, 32'h3f80_0000);
        send_fp(16'h3f81, 16'h3f80, 16'hbf80, 16'h3f80, 32'h0000_0000);
        close_test();

        begin_test("specials");
        send_fp(16'h7fc0, 16'h3f80, 16'h0000, 16'h0000, 32'h3f80_0000);
        send_fp(16'h7f80, 16'h0000, 16'h0000, 16'h0000, 32'h3f80_0000);
        send_fp(16'h3f80, 16'h3f80, 16'h8000, 16'hff80, 32'h0000_0000);
        send_fp(16'h3f80, 16'h3f80, 16'h0000, 16'h0000, 32'h7fc0_0001);
        send_fp(16'h7f80, 16'hbf80, 16'h0000, 16'h0000, 32'h3f80_0000);
        send_fp(16'h0000, 16'h0000, 16'h0000, 16'h0000, 32'h7f80_0000);
        send_fp(16'h7f80, 16'h3f80, 16'h0000, 16'h0000, 32'hff80_0000);
        send_fp(16'h7f80, 16'h3f80, 16'hff80, 16'hbf80, 32'h7f80_0000);
        // Exponent range limits
        send_fp(16'h7f00, 16'h7f00, 16'h0000, 16'h0000, 32'h0000_0000);
        send_fp(16'h7f00, 16'hff00, 16'h0000, 16'h0000, 32'h0000_0000);
        send_fp(16'h5980, 16'h5980, 16'h0000, 16'h0000, 32'h7f7f_ffff);
        send_fp(16'h1c80, 16'h1c80, 16'h0000, 16'h0000, 32'h0000_0000);
        send_fp(16'h9c80, 16'h1c80, 16'h0000, 16'h0000, 32'h0000_0000);
        close_test();

        begin_test("integer_mode");
        // Carry out of the low 25 bits, then wrap
        send_req(1'b1, 16'hff80, 16'hff80, 16'hff80, 16'hff80, 32'h7fff_ffff);
        send_req(1'b1, 16'h007f, 16'hff80, 16'h007f, 16'hff80, 32'h8000_0000);
        for (int i = 0; i < 200; i++) begin
            send_rand_int();
        end
        close_test();

        begin_test("streaming");
        for (int i = 0; i < 40; i++) begin
            // One idle gap halfway through
            if (i == 20) begin
                idle(3);
            end
            if ($random(seed) & 1) begin
                send_rand_int();
            end else begin
                send_rand_fp();
            end
        end
        close_test();

        $display("Tests run %0d, clean %0d, with errors %0d, responses %0d, errors %0d",
                 tests_run, tests_run - tests_bad, tests_bad, checks, total_errors());
        if (total_errors() == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: fedp_unit.f
+incdir+.
fedp_pkg.sv
fedp_lzc.sv
fedp_mul_stage.sv
fedp_align_acc.sv
fedp_norm_round.sv
fedp_unit.sv
tb_fedp_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the fedp_unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f fedp_unit.f \
    --top-module tb_fedp_unit -o tb_fedp_unit > sim.log 2>&1 \
    && ./obj_dir/tb_fedp_unit >> sim.log 2>&1 \
    || echo "Test failed" >> sim.log
cat sim.log
if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0
